/* fir_params.svh */
//////////////////////////////////////////////////
// FIR core sizing constants
// Word widths, address widths, delay line depth
// and accumulator width shared by all FIR blocks
//////////////////////////////////////////////////

`ifndef FIR_PARAMS_SVH
`define FIR_PARAMS_SVH

// Width of one signed tap or sample word
`define FIR_DATA_W 16

// Width of the tap index and the tap count, counts run 1 to 15
`define FIR_TAP_AW 4

// Number of history entries, two to the power FIR_TAP_AW
`define FIR_TAP_DEPTH 16

// Width of the sample address and the sample count, counts run 1 to 255
`define FIR_DATA_AW 8

// Two products' worth of bits plus the tap index width
// Summing up to 2**FIR_TAP_AW products can never lose a carry
`define FIR_ACC_W 36

`endif

/* fir_pkg.sv */
//////////////////////////////////////////////////
// FIR shared types
// Frame settings, operand tags and stream beats
//////////////////////////////////////////////////

`default_nettype none

`include "fir_params.svh"

package fir_pkg;

  // Counts latched for one frame
  typedef struct packed {
    logic [`FIR_TAP_AW-1:0]  tap_num;
    logic [`FIR_DATA_AW-1:0] data_num;
  } fir_cfg_t;

  // Control that rides along with one coefficient and sample pair
  typedef struct packed {
    logic valid;
    logic first;
    logic last;
    logic last_sample;
  } fir_tag_t;

  // One result beat on the output stream
  // The last bit marks the final sample of the frame
  typedef struct packed {
    logic signed [`FIR_ACC_W-1:0] result;
    logic                         last;
  } fir_beat_t;

endpackage

`default_nettype wire

/* fir_config.sv */
//////////////////////////////////////////////////
// FIR configuration block
// Accepts start, latches the frame counts and
// tracks busy until the final beat has left
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "fir_params.svh"

module fir_config (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   start,
  input  wire logic [`FIR_TAP_AW-1:0] tap_num,
  input  wire logic [`FIR_DATA_AW-1:0] data_num,
  input  wire logic                   frame_end,
  output logic                        go,
  output fir_pkg::fir_cfg_t           cfg,
  output logic                        done
);

  // High from an accepted start until the frame is finished
  logic busy;
  // A start only counts while no frame is running
  logic start_ok;

  assign start_ok = start && !busy;

  //////////////////////////////////////////////////
  // Frame control
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy          <= 1'b0;
      go            <= 1'b0;
      done          <= 1'b0;
      cfg.tap_num   <= '0;
      cfg.data_num  <= '0;
    end else begin
      // The sequencer sees go one cycle after the accepted start
      go   <= start_ok;
      // Done trails the last handshake by one cycle
      done <= frame_end;
      if (start_ok) begin
        busy         <= 1'b1;
        cfg.tap_num  <= tap_num;
        cfg.data_num <= data_num;
      end else if (frame_end) begin
        // Busy drops on the same edge that raises done
        busy <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* fir_sequencer.sv */
//////////////////////////////////////////////////
// FIR frame sequencer
// Walks samples and taps, reads both RAMs, drives
// the delay line and tags each operand pair
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "fir_params.svh"

module fir_sequencer (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic                    go,
  input  wire fir_pkg::fir_cfg_t       cfg,
  input  wire logic                    stall,
  output logic [`FIR_TAP_AW-1:0]       tap_addr,
  output logic                         tap_en,
  output logic [`FIR_DATA_AW-1:0]      data_addr,
  output logic                         data_en,
  output logic                         clr,
  output logic                         shift,
  output logic [`FIR_TAP_AW-1:0]       rd_idx,
  output fir_pkg::fir_tag_t            tag
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_LOAD = 2'd1;
  localparam logic [1:0] ST_TAPS = 2'd2;

  logic [1:0]              state;
  // Load takes two cycles, a RAM read and then the shift
  logic                    load_phase;
  logic [`FIR_TAP_AW-1:0]  tap_cnt;
  logic [`FIR_DATA_AW-1:0] smp_cnt;
  logic                    last_tap;
  logic                    last_smp;

  assign last_tap = (tap_cnt == cfg.tap_num - 1'b1);
  assign last_smp = (smp_cnt == cfg.data_num - 1'b1);

  //////////////////////////////////////////////////
  // Memory and delay line controls
  //////////////////////////////////////////////////

  // The history is wiped on the go pulse, before the first load
  assign clr       = (state == ST_IDLE) && go;
  assign data_addr = smp_cnt;
  // Enables drop during a stall, so each RAM keeps its read data
  assign data_en   = (state == ST_LOAD) && !load_phase && !stall;
  // The sample read in the previous cycle is on data_rdata now
  assign shift     = (state == ST_LOAD) && load_phase && !stall;
  assign tap_addr  = tap_cnt;
  assign tap_en    = (state == ST_TAPS) && !stall;
  // Entry i of the history pairs with coefficient i
  assign rd_idx    = tap_cnt;

  //////////////////////////////////////////////////
  // State machine and counters
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= ST_IDLE;
      load_phase <= 1'b0;
      tap_cnt    <= '0;
      smp_cnt    <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (go) begin
            state      <= ST_LOAD;
            load_phase <= 1'b0;
            tap_cnt    <= '0;
            smp_cnt    <= '0;
          end
        end
        ST_LOAD: begin
          if (!stall) begin
            if (!load_phase) begin
              load_phase <= 1'b1;
            end else begin
              load_phase <= 1'b0;
              tap_cnt    <= '0;
              state      <= ST_TAPS;
            end
          end
        end
        ST_TAPS: begin
          if (!stall) begin
            if (last_tap) begin
              tap_cnt <= '0;
              // The last tap of the last sample ends the frame
              if (last_smp) begin
                state <= ST_IDLE;
              end else begin
                smp_cnt <= smp_cnt + 1'b1;
                state   <= ST_LOAD;
              end
            end else begin
              tap_cnt <= tap_cnt + 1'b1;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Tag is registered so it lines up with the RAM and history read data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tag <= '0;
    end else if (!stall) begin
      tag.valid       <= (state == ST_TAPS);
      tag.first       <= (tap_cnt == '0);
      tag.last        <= last_tap;
      tag.last_sample <= last_smp;
    end
  end

endmodule

`default_nettype wire

/* fir_delay_line.sv */
//////////////////////////////////////////////////
// FIR sample history
// Shift register of recent samples with a one
// cycle clear and a registered indexed read
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "fir_params.svh"

module fir_delay_line (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire logic                          clr,
  input  wire logic                          shift,
  input  wire logic [`FIR_TAP_AW-1:0]        rd_idx,
  input  wire logic                          stall,
  input  wire logic signed [`FIR_DATA_W-1:0] sample,
  output logic signed [`FIR_DATA_W-1:0]      hist
);

  // Entry 0 always holds the newest sample
  logic signed [`FIR_DATA_W-1:0] mem [`FIR_TAP_DEPTH];

  // Everything older than the first sample of a frame reads as zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `FIR_TAP_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (clr) begin
      for (int i = 0; i < `FIR_TAP_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (shift) begin
      // Oldest entry falls off the far end
      for (int i = `FIR_TAP_DEPTH - 1; i > 0; i--) begin
        mem[i] <= mem[i-1];
      end
      mem[0] <= sample;
    end
  end

  // Same one cycle latency as the coefficient RAM
  // During a stall the index is frozen and the read is held as well
  always_ff @(posedge clk) begin
    if (!stall) begin
      hist <= mem[rd_idx];
    end
  end

endmodule

`default_nettype wire

/* fir_mac.sv */
//////////////////////////////////////////////////
// FIR multiply-accumulate pipeline
// Product, accumulator and result register with
// back-pressure from the result stream
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "fir_params.svh"

module fir_mac (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire logic signed [`FIR_DATA_W-1:0] coef,
  input  wire logic signed [`FIR_DATA_W-1:0] hist,
  input  wire fir_pkg::fir_tag_t             tag,
  input  wire logic                          ready,
  output logic                               stall,
  output logic                               valid,
  output fir_pkg::fir_beat_t                 beat,
  output logic                               frame_end
);

  // Product stage
  logic signed [2*`FIR_DATA_W-1:0] prod_q;
  fir_pkg::fir_tag_t               ptag_q;
  // Product widened to the accumulator with its sign carried up
  logic signed [`FIR_ACC_W-1:0]    prod_ext;

  // Accumulator stage
  logic signed [`FIR_ACC_W-1:0]    acc_q;
  fir_pkg::fir_tag_t               atag_q;

  // Result stage
  logic                            res_load;
  logic                            hsk;

  assign prod_ext = prod_q;
  assign hsk      = valid && ready;

  //////////////////////////////////////////////////
  // Back-pressure
  //////////////////////////////////////////////////

  // A finished sum is waiting but the previous beat is still unaccepted
  // Every stage in front of the result register then holds still
  assign stall     = valid && !ready && atag_q.valid && atag_q.last;
  assign res_load  = atag_q.valid && atag_q.last && !stall;
  assign frame_end = hsk && beat.last;

  //////////////////////////////////////////////////
  // Multiply and accumulate
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!stall) begin
      prod_q <= coef * hist;
    end
  end

  // A first tap restarts the sum, later taps add onto it
  always_ff @(posedge clk) begin
    if (!stall && ptag_q.valid) begin
      if (ptag_q.first) begin
        acc_q <= prod_ext;
      end else begin
        acc_q <= acc_q + prod_ext;
      end
    end
  end

  // Tags move in step with the data, bubbles included
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptag_q <= '0;
      atag_q <= '0;
    end else if (!stall) begin
      ptag_q <= tag;
      atag_q <= ptag_q;
    end
  end

  //////////////////////////////////////////////////
  // Result register
  //////////////////////////////////////////////////

  // Beat only changes on a load, which cannot happen while it is held
  always_ff @(posedge clk) begin
    if (res_load) begin
      beat.result <= acc_q;
      beat.last   <= atag_q.last_sample;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid <= 1'b0;
    end else if (res_load) begin
      valid <= 1'b1;
    end else if (hsk) begin
      valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* fir_core.sv */
//////////////////////////////////////////////////
// FIR filter core top level
// Reads taps and samples from two external RAMs
// and streams one filtered result per sample
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "fir_params.svh"

module fir_core (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire logic                          start,
  input  wire logic [`FIR_TAP_AW-1:0]        tap_num,
  input  wire logic [`FIR_DATA_AW-1:0]       data_num,
  input  wire logic signed [`FIR_DATA_W-1:0] tap_rdata,
  input  wire logic signed [`FIR_DATA_W-1:0] data_rdata,
  input  wire logic                          ready,
  output logic [`FIR_TAP_AW-1:0]             tap_addr,
  output logic                               tap_en,
  output logic [`FIR_DATA_AW-1:0]            data_addr,
  output logic                               data_en,
  output logic                               valid,
  output fir_pkg::fir_beat_t                 beat,
  output logic                               done
);

  logic                          go;
  fir_pkg::fir_cfg_t             cfg;
  logic                          frame_end;
  logic                          stall;
  logic                          clr;
  logic                          shift;
  logic [`FIR_TAP_AW-1:0]        rd_idx;
  fir_pkg::fir_tag_t             tag;
  logic signed [`FIR_DATA_W-1:0] hist;

  fir_config config_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .tap_num   (tap_num),
    .data_num  (data_num),
    .frame_end (frame_end),
    .go        (go),
    .cfg       (cfg),
    .done      (done)
  );

  fir_sequencer sequencer_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .go        (go),
    .cfg       (cfg),
    .stall     (stall),
    .tap_addr  (tap_addr),
    .tap_en    (tap_en),
    .data_addr (data_addr),
    .data_en   (data_en),
    .clr       (clr),
    .shift     (shift),
    .rd_idx    (rd_idx),
    .tag       (tag)
  );

  // Samples go straight from the data RAM into the history
  fir_delay_line delay_line_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .clr    (clr),
    .shift  (shift),
    .rd_idx (rd_idx),
    .stall  (stall),
    .sample (data_rdata),
    .hist   (hist)
  );

  fir_mac mac_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .coef      (tap_rdata),
    .hist      (hist),
    .tag       (tag),
    .ready     (ready),
    .stall     (stall),
    .valid     (valid),
    .beat      (beat),
    .frame_end (frame_end)
  );

endmodule

`default_nettype wire

/* fir_sva.sv */
//////////////////////////////////////////////////
// FIR core stream and control assertions
// Bound into the core top level
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module fir_sva (
  input wire logic               clk,
  input wire logic               rst_n,
  input wire logic               valid,
  input wire logic               ready,
  input wire logic               done,
  input wire fir_pkg::fir_beat_t beat
);

  // A beat the sink has not taken stays on the bus unchanged
  a_beat_held: assert property (@(posedge clk) disable iff (!rst_n)
    (valid && !ready) |=> (valid && $stable(beat)))
    else $error("beat changed or valid dropped under back-pressure");

  // Done lasts one cycle per frame
  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done |=> !done)
    else $error("done stayed high for more than one cycle");

  // The stream and done come out of reset quiet
  a_reset_quiet: assert property (@(posedge clk)
    $rose(rst_n) |-> (!valid && !done))
    else $error("valid or done high right after reset");

endmodule

bind fir_core fir_sva sva_i (
  .clk   (clk),
  .rst_n (rst_n),
  .valid (valid),
  .ready (ready),
  .done  (done),
  .beat  (beat)
);

`default_nettype wire

/* fir_tb.sv */
//////////////////////////////////////////////////
// FIR core testbench
// RAM models, random frames, a convolution model
// and checks on the result stream and done pulse
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "fir_params.svh"

module fir_tb;

  // Sum of samples times (taps + 8) over all frames, four times over, plus slack
  localparam int CYCLE_LIMIT =
    4 * (40 * 19 + 60 * 15 + 20 * 9 + 20 * 23 + 30 * 13 + 25 * 21) + 1000;
  localparam logic signed [`FIR_DATA_W-1:0] MOST_NEG = {1'b1, {(`FIR_DATA_W-1){1'b0}}};

  logic                          clk = 1'b0;
  logic                          rst_n;
  logic                          start;
  logic [`FIR_TAP_AW-1:0]        tap_num;
  logic [`FIR_DATA_AW-1:0]       data_num;
  logic signed [`FIR_DATA_W-1:0] tap_rdata = '0;
  logic signed [`FIR_DATA_W-1:0] data_rdata = '0;
  logic                          ready = 1'b0;
  logic [`FIR_TAP_AW-1:0]        tap_addr;
  logic                          tap_en;
  logic [`FIR_DATA_AW-1:0]       data_addr;
  logic                          data_en;
  logic                          valid;
  fir_pkg::fir_beat_t            beat;
  logic                          done;

  // RAM contents, also read by the model
  logic signed [`FIR_DATA_W-1:0] tap_mem [`FIR_TAP_DEPTH];
  logic signed [`FIR_DATA_W-1:0] data_mem [1 << `FIR_DATA_AW];
  // Expected beats in stream order, result above the last bit
  logic [63:0] expq [$];
  logic        bp_mode = 1'b0;
  string       test_name = "reset";
  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          err_base = 0;
  int          beat_total = 0;
  int          done_total = 0;
  int          cycles = 0;

  // All ports share their names with the DUT
  fir_core fir_core_i (.*);

  always #20 clk = ~clk;

  //////////////////////////////////////////////////
  // RAM models, sink and monitors
  //////////////////////////////////////////////////

  // Both RAMs return data one cycle after an enabled read and hold it otherwise
  always @(posedge clk) begin
    if (tap_en) begin
      tap_rdata <= tap_mem[tap_addr];
    end
    if (data_en) begin
      data_rdata <= data_mem[data_addr];
    end
  end

  // The sink takes every beat, or under back-pressure flips ready about one cycle in eight
  // Long low bursts keep a finished sum waiting behind the result register
  always @(posedge clk) begin
    if (bp_mode) begin
      ready <= ready ^ ($urandom % 8 == 0);
    end else begin
      ready <= 1'b1;
    end
  end

  // Each accepted beat is compared with the oldest expected result
  always @(posedge clk) begin
    if (rst_n && valid && ready) begin
      beat_total++;
      if (expq.size() == 0) begin
        errors++;
        $display("Beat accepted in %s while the model expected none", test_name);
      end else begin
        check_value(test_name, expq.pop_front(), 64'(beat));
      end
    end
    if (done) begin
      done_total++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout reached after %0d cycles in %s", cycles, test_name);
      $display("Something failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Model and helper tasks
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic fill_random();
    for (int i = 0; i < `FIR_TAP_DEPTH; i++) begin
      tap_mem[i] = `FIR_DATA_W'($urandom);
    end
    for (int i = 0; i < (1 << `FIR_DATA_AW); i++) begin
      data_mem[i] = `FIR_DATA_W'($urandom);
    end
  endtask

  task automatic fill_most_negative();
    foreach (tap_mem[i])
      tap_mem[i] = MOST_NEG;
    foreach (data_mem[i])
      data_mem[i] = MOST_NEG;
  endtask

  // Direct convolution, taps that reach before sample 0 see zero history
  task automatic load_model(input int n, input int m);
    longint      sum;
    logic [63:0] exp_beat;
    for (int k = 0; k < m; k++) begin
      sum = 0;
      for (int i = 0; i < n && i <= k; i++) begin
        sum += longint'(tap_mem[i]) * longint'(data_mem[k - i]);
      end
      exp_beat = '0;
      exp_beat[`FIR_ACC_W:1] = sum[`FIR_ACC_W-1:0];
      exp_beat[0] = (k == m - 1);
      expq.push_back(exp_beat);
    end
  endtask

  // One frame from start to done, optionally with a stray start halfway in
  task automatic run_frame(input int n, input int m, input bit poke);
    int beats_before;
    int wait_cnt;
    load_model(n, m);
    beats_before = beat_total;
    wait_cnt = 0;
    @(posedge clk);
    start    <= 1'b1;
    tap_num  <= `FIR_TAP_AW'(n);
    data_num <= `FIR_DATA_AW'(m);
    @(posedge clk);
    start <= 1'b0;
    while (!done) begin
      @(posedge clk);
      wait_cnt++;
      if (poke && wait_cnt == 20) begin
        start    <= 1'b1;
        tap_num  <= `FIR_TAP_AW'(3);
        data_num <= `FIR_DATA_AW'(7);
      end else begin
        start <= 1'b0;
      end
    end
    check_value({test_name, " beat count"}, m, beat_total - beats_before);
    check_value({test_name, " beats left"}, 0, expq.size());
  endtask

  // A few idle cycles show up any done pulse beyond one per frame
  task automatic check_done_total(input int frames);
    repeat (5) @(posedge clk);
    check_value({test_name, " done pulses"}, frames, done_total);
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == err_base) begin
      $display("%s: no errors", test_name);
    end else begin
      $display("%s: %0d errors", test_name, errors - err_base);
    end
    err_base = errors;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(20));
    rst_n    = 1'b0;
    start    = 1'b0;
    tap_num  = '0;
    data_num = '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    // Nothing may move before the first start
    test_name = "idle";
    repeat (50) begin
      @(posedge clk);
      check_value(test_name, 64'd0, {60'd0, valid, done, tap_en, data_en});
    end
    end_test();

    test_name = "basic";
    fill_random();
    run_frame(11, 40, 1'b0);
    check_done_total(1);
    end_test();

    test_name = "backpressure";
    fill_random();
    @(posedge clk);
    bp_mode <= 1'b1;
    run_frame(7, 60, 1'b0);
    bp_mode <= 1'b0;
    check_done_total(2);
    end_test();

    // Largest products, the sum needs the full accumulator width
    test_name = "extremes";
    fill_most_negative();
    run_frame(1, 20, 1'b0);
    run_frame(15, 20, 1'b0);
    check_done_total(4);
    end_test();

    // The second frame starts straight after the first done
    test_name = "back to back";
    fill_random();
    run_frame(5, 30, 1'b1);
    fill_random();
    run_frame(13, 25, 1'b0);
    check_done_total(6);
    end_test();

    $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
fir_pkg.sv
fir_config.sv
fir_sequencer.sv
fir_delay_line.sv
fir_mac.sv
fir_core.sv
fir_sva.sv
fir_tb.sv

/* Makefile */
# Build and run the FIR testbench with Verilator, pass only if the log says so

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module fir_tb -f compile.f -o fir_sim
	./obj_dir/fir_sim | tee sim.log
	grep -q "^Everything OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
